// ==== wiener_config.svh ====
// design-wide sizes for the block Wiener denoiser
// BLK_N must be a power of two and equal to 2**BLK_LOG2
`ifndef WIENER_CONFIG_SVH
`define WIENER_CONFIG_SVH

// grey pixel width, the clip range is 0 to 2**PIX_W-1
`define PIX_W 8

// samples per block
`define BLK_N 64

// log2 of BLK_N, used for the mean shift and the pointers
`define BLK_LOG2 6

// APB byte address width, registers at 0x0 and 0x4
`define APB_AW 4

`endif

// ==== wiener_pkg.sv ====
// shared types for the denoiser datapath and control
// needs wiener_config.svh for PIX_W
`include "wiener_config.svh"

package wiener_pkg;

	typedef logic [`PIX_W-1:0] pix_t;          // one grey sample

	typedef struct packed {
		logic valid;                           // beat present
		pix_t data;                            // pixel value
		logic last;                            // 64th pixel, output side only
	} pix_stream_t;

	typedef struct packed {
		pix_t               mean;              // floor mean of the block
		logic [2*`PIX_W-1:0] variance;         // floor variance of the block
	} blk_stats_t;

	typedef struct packed {
		logic [31:0] mag;                      // 16.16 magnitude
		logic        pos;                      // 1 when variance >= noise_var
	} gain_t;

	typedef enum logic [1:0] {
		FILL, STATS, DIVIDE, DRAIN
	} ctrl_state_t;

endpackage

// ==== wiener_ctrl.sv ====
// block sequencer and APB registers, APB has no wait states
// noise_var at 0x0 (16 bits rw), blocks_done at 0x4 (ro)
`timescale 1ns/1ps
`include "wiener_config.svh"

module wiener_ctrl import wiener_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	input  logic              in_valid,
	output logic              in_ready,
	output logic              wr_en,
	output logic              stats_start,
	input  logic              stats_ready,
	output logic              div_start,
	input  logic              div_done,
	output logic              rd_en,
	output logic              rd_last,
	output logic [15:0]       noise_var,
	output ctrl_state_t       state
);
	localparam int unsigned LAST = `BLK_N - 1;

	ctrl_state_t          next_state;
	logic [`BLK_LOG2-1:0] cnt;                 // sample index, shared by FILL and DRAIN
	logic                 armed;               // holds in_ready low for the first cycle
	logic [31:0]          blocks_done;
	logic                 apb_wr;

	assign pready    = 1'b1;                   // zero wait states
	assign apb_wr    = psel && penable && pwrite;
	assign in_ready  = armed && (state == FILL);
	assign wr_en     = in_valid && in_ready;
	assign div_start = (state == STATS) && stats_ready;
	assign rd_en     = (state == DRAIN);
	assign rd_last   = rd_en && (cnt == LAST[`BLK_LOG2-1:0]);

	always_comb begin
		next_state = state;
		case (state)
			FILL:    if (wr_en && cnt == LAST[`BLK_LOG2-1:0]) next_state = STATS;
			STATS:   if (stats_ready) next_state = DIVIDE;
			DIVIDE:  if (div_done) next_state = DRAIN;
			DRAIN:   if (rd_last) next_state = FILL;
			default: next_state = FILL;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= FILL;
			cnt         <= '0;
			armed       <= 1'b0;
			stats_start <= 1'b0;
			blocks_done <= '0;
			noise_var   <= '0;
		end else begin
			state       <= next_state;
			armed       <= 1'b1;
			stats_start <= (state == FILL) && wr_en && (cnt == LAST[`BLK_LOG2-1:0]); // cycle after 64th beat
			if (wr_en || rd_en) cnt <= cnt + 1'b1;   // wraps back to 0 at BLK_N
			if (rd_last) blocks_done <= blocks_done + 1'b1;
			if (apb_wr && paddr == `APB_AW'h0) noise_var <= pwdata[15:0];
		end
	end

	always_comb begin
		case (paddr)
			`APB_AW'h0: prdata = {16'h0, noise_var};
			`APB_AW'h4: prdata = blocks_done;
			default:    prdata = '0;       // unmapped reads return zero
		endcase
	end

	// the divider reports only while the FSM waits on it
	assert property (@(posedge clk) disable iff (!rst_n) div_done |-> state == DIVIDE);
	// the last read closes the block straight back into FILL
	assert property (@(posedge clk) disable iff (!rst_n) rd_last |=> (state == FILL && !rd_en));

endmodule

// ==== block_stats.sv ====
// block mean and variance, floor division by BLK_N throughout
// results valid two cycles after stats_start, stats_ready pulses then
`timescale 1ns/1ps
`include "wiener_config.svh"

module block_stats import wiener_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  pix_t       pix,
	input  logic       wr_en,
	input  logic       stats_start,
	output blk_stats_t stats,
	output logic       stats_ready
);
	localparam int SUM_W = `PIX_W + `BLK_LOG2;     // 14 bits for 64 x 255
	localparam int SQ_W  = 2 * `PIX_W + `BLK_LOG2; // 22 bits for 64 x 255^2

	logic [SUM_W-1:0]     sum;
	logic [SQ_W-1:0]      sum_sq;
	logic                 var_step;                // second stats cycle
	pix_t                 mean_r;
	logic [2*`PIX_W-1:0]  sq_mean_r;               // mean of the squares
	logic [2*`PIX_W-1:0]  var_r;
	logic [2*`PIX_W-1:0]  pix_sq;

	assign pix_sq = pix * pix;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum         <= '0;
			sum_sq      <= '0;
			var_step    <= 1'b0;
			stats_ready <= 1'b0;
		end else begin
			var_step    <= stats_start;
			stats_ready <= var_step;
			if (var_step) begin
				sum    <= '0;                          // ready for the next block
				sum_sq <= '0;
			end else if (wr_en) begin
				sum    <= sum + SUM_W'(pix);
				sum_sq <= sum_sq + SQ_W'(pix_sq);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stats_start) begin
			mean_r    <= pix_t'(sum >> `BLK_LOG2);
			sq_mean_r <= (2*`PIX_W)'(sum_sq >> `BLK_LOG2);
		end
		if (var_step) var_r <= sq_mean_r - mean_r * mean_r; // never negative with floors
	end

	assign stats.mean     = mean_r;
	assign stats.variance = var_r;

endmodule

// ==== gain_divider.sv ====
// restoring divider for |var - noise_var| << 16 / var, 32 quotient bits
// first bit is taken on the div_start edge, gain valid with div_done
`timescale 1ns/1ps

module gain_divider import wiener_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       div_start,
	input  blk_stats_t stats,
	input  logic [15:0] noise_var,
	output gain_t      gain,
	output logic       div_done
);
	logic        busy;
	logic [4:0]  cnt;                       // quotient bits already formed
	logic [15:0] rem, den;
	logic [31:0] quo;                       // numerator shifts out, quotient shifts in
	logic        pos;
	logic        pos_in;
	logic [15:0] diff_in;
	logic [15:0] src_rem, src_den;
	logic [31:0] src_quo;
	logic [16:0] trial;
	logic        q_bit;

	assign pos_in  = stats.variance >= noise_var;
	assign diff_in = pos_in ? stats.variance - noise_var : noise_var - stats.variance;
	assign src_rem = div_start ? 16'h0 : rem;
	assign src_quo = div_start ? {diff_in, 16'h0} : quo;
	assign src_den = div_start ? ((stats.variance == 0) ? 16'd1 : stats.variance) : den; // flat block
	assign trial   = {src_rem, src_quo[31]};
	assign q_bit   = trial >= {1'b0, src_den};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			cnt      <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= busy && (cnt == 5'd31);
			if (div_start) begin
				busy <= 1'b1;
				cnt  <= 5'd1;
			end else if (busy) begin
				cnt  <= cnt + 1'b1;
				if (cnt == 5'd31) busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (div_start || busy) begin
			rem <= q_bit ? 16'(trial - {1'b0, src_den}) : trial[15:0];
			quo <= {src_quo[30:0], q_bit};
			den <= src_den;
		end
		if (div_start) pos <= pos_in;
	end

	assign gain.mag = quo;
	assign gain.pos = pos;

	// no restart mid divide, and the result lands exactly 32 cycles on
	assert property (@(posedge clk) disable iff (!rst_n) div_start |-> (!busy ##32 div_done));

endmodule

// ==== block_buffer.sv ====
// one-block pixel store, writes during FILL and in-order reads during DRAIN
// read data is registered, rd_valid follows rd_en by one cycle
`timescale 1ns/1ps
`include "wiener_config.svh"

module block_buffer import wiener_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  pix_t        pix,
	input  logic        wr_en,
	input  logic        rd_en,
	input  ctrl_state_t state,
	output pix_t        rd_pix,
	output logic        rd_valid
);
	pix_t                 mem [`BLK_N];
	logic [`BLK_LOG2-1:0] wr_ptr, rd_ptr;      // wrap at BLK_N by width

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			if (rd_en) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= pix;
		if (rd_en) rd_pix <= mem[rd_ptr];
	end

	// the controller must not let new pixels in while the block replays
	assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> state != DRAIN);

endmodule

// ==== wiener_pixel.sv ====
// out = mean +/- ((gain * |pix - mean|) >> 16), clipped to the pixel range
// stats and gain must stay stable for the whole drain
`timescale 1ns/1ps
`include "wiener_config.svh"

module wiener_pixel import wiener_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  pix_t        rd_pix,
	input  logic        rd_valid,
	input  logic        rd_last,
	input  blk_stats_t  stats,
	input  gain_t       gain,
	output pix_stream_t out_beat
);
	localparam int PROD_W = 32 + `PIX_W;
	localparam int RES_W  = PROD_W - 16 + 2;       // room for carry and sign

	logic                    last_q;             // rd_last aligned to rd_valid
	logic                    ge_mean;
	pix_t                    abs_diff;
	logic [PROD_W-1:0]       prod;
	logic [PROD_W-17:0]      scaled;
	logic signed [RES_W-1:0] res;
	pix_t                    clipped;

	assign ge_mean  = rd_pix >= stats.mean;
	assign abs_diff = ge_mean ? rd_pix - stats.mean : stats.mean - rd_pix;
	assign prod     = gain.mag * abs_diff;
	assign scaled   = prod[PROD_W-1:16];         // drop the 16 fraction bits

	always_comb begin
		if (gain.pos == ge_mean) res = $signed(RES_W'(stats.mean)) + $signed(RES_W'(scaled));
		else                     res = $signed(RES_W'(stats.mean)) - $signed(RES_W'(scaled));
		if (res < 0)                          clipped = '0;
		else if (res > $signed(RES_W'({`PIX_W{1'b1}}))) clipped = '1; // saturate at 255
		else                                  clipped = res[`PIX_W-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_q   <= 1'b0;
			out_beat <= '0;
		end else begin
			last_q         <= rd_last;
			out_beat.valid <= rd_valid;
			out_beat.data  <= clipped;
			out_beat.last  <= rd_valid && last_q;
		end
	end

endmodule

// ==== wiener_denoise_top.sv ====
// Wiener block denoiser, APB for config, valid/ready pixel input
// output has no ready, the sink takes one pixel per cycle while valid
`timescale 1ns/1ps
`include "wiener_config.svh"

module wiener_denoise_top import wiener_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	input  pix_stream_t       in_beat,       // last is ignored, blocks are counted
	output logic              in_ready,
	output pix_stream_t       out_beat
);
	logic        wr_en, stats_start, stats_ready, div_start, div_done;
	logic        rd_en, rd_last, rd_valid;
	logic [15:0] noise_var;
	ctrl_state_t state;
	blk_stats_t  stats;
	gain_t       gain;
	pix_t        rd_pix;

	wiener_ctrl u_wiener_ctrl (.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .in_valid(in_beat.valid), .in_ready, .wr_en, .stats_start,
		.stats_ready, .div_start, .div_done, .rd_en, .rd_last, .noise_var, .state);

	block_stats u_block_stats (.clk, .rst_n, .pix(in_beat.data), .wr_en, .stats_start,
		.stats, .stats_ready);

	gain_divider u_gain_divider (.clk, .rst_n, .div_start, .stats, .noise_var, .gain,
		.div_done);

	block_buffer u_block_buffer (.clk, .rst_n, .pix(in_beat.data), .wr_en, .rd_en, .state,
		.rd_pix, .rd_valid);

	wiener_pixel u_wiener_pixel (.clk, .rst_n, .rd_pix, .rd_valid, .rd_last, .stats, .gain,
		.out_beat);

endmodule

// ==== tb_wiener_denoise.sv ====
// runs from the project root, reads wiener_stimulus.txt there
// every output pixel is checked against an integer model of the block update
`timescale 1ns/1ps
`include "wiener_config.svh"

module tb_wiener_denoise import wiener_pkg::*; ();
	logic              clk = 1'b0;
	logic              rst_n, psel, penable, pwrite, pready, in_ready;
	logic [`APB_AW-1:0] paddr;
	logic [31:0]       pwdata, prdata;
	pix_stream_t       in_beat, out_beat;
	logic [31:0]       rng;                  // xorshift state, pixels and idle gaps
	int                n_blocks = 0;
	bit                loaded = 1'b0;        // watchdog starts once the file is in
	int                out_seen = 0;         // all valid output beats so far
	pix_t              blk [`BLK_N];         // block being sent
	pix_t              exp_pix [`BLK_N];     // model output for that block

	always #20 clk = ~clk;                   // 40 ns period

	wiener_denoise_top u_wiener_denoise_top (.clk, .rst_n, .psel, .penable, .pwrite, .paddr,
		.pwdata, .prdata, .pready, .in_beat, .in_ready, .out_beat);

	always @(negedge clk) if (rst_n && out_beat.valid) out_seen++;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_pix(input string name, input pix_t got, input pix_t exp);
		if (got !== exp) fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_last(input string name, input logic got, input logic exp);
		if (got !== exp) fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_apb(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		psel    = 1'b1;                      // setup
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk) penable = 1'b1;       // access, no wait states
		check_ready("pready", pready, 1'b1);
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk) penable = 1'b1;
		check_ready("pready", pready, 1'b1);
		data = prdata;                       // prdata is decoded from paddr, stable here
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// floor mean and variance, 16.16 gain, then mean +/- scaled distance and clip
	task automatic build_model(input longint nv);
		longint sum, sq, mean, vr, diff, den, mag, ad, sc, res;
		bit     pos, ge;
		sum = 0;
		sq  = 0;
		for (int i = 0; i < `BLK_N; i++) begin
			sum += blk[i];
			sq  += blk[i] * blk[i];
		end
		mean = sum / `BLK_N;
		vr   = sq / `BLK_N - mean * mean;
		pos  = vr >= nv;
		diff = pos ? vr - nv : nv - vr;
		den  = (vr == 0) ? 1 : vr;               // flat block
		mag  = (diff * 65536) / den;
		for (int i = 0; i < `BLK_N; i++) begin
			ge  = blk[i] >= mean;
			ad  = ge ? blk[i] - mean : mean - blk[i];
			sc  = (mag * ad) / 65536;
			res = (pos == ge) ? mean + sc : mean - sc;
			if (res < 0) res = 0;
			if (res > 255) res = 255;
			exp_pix[i] = pix_t'(res);
		end
	endtask

	task automatic send_block();
		int idx;
		idx = 0;
		while (idx < `BLK_N) begin
			@(negedge clk);
			rng = xorshift32(rng);
			if (rng[1:0] == 2'b00) in_beat.valid = 1'b0;   // idle gap, about one in four
			else begin
				in_beat.valid = 1'b1;
				in_beat.data  = blk[idx];
				if (in_ready) idx++;            // in_ready only moves on posedge
			end
		end
		@(negedge clk) in_beat.valid = 1'b0;
	endtask

	task automatic collect_block();
		int idx;
		idx = 0;
		while (idx < `BLK_N) begin
			@(negedge clk);
			if (out_beat.valid) begin
				check_pix($sformatf("out_beat.data[%0d]", idx), out_beat.data, exp_pix[idx]);
				check_last($sformatf("out_beat.last[%0d]", idx), out_beat.last, idx == `BLK_N - 1);
				idx++;
			end
		end
	endtask

	initial begin
		int          fd, val, b;
		string       line;
		int          nv, base, spread, done;
		int          nv_q[$], base_q[$], spread_q[$], done_q[$];
		logic [31:0] rd;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		in_beat = '0;
		rng = 32'h8e65_5a81;
		fd = $fopen("wiener_stimulus.txt", "r");
		if (fd == 0) fail_run("cannot open wiener_stimulus.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] != "#") begin   // skip the column notes
				if ($sscanf(line, "%h %h %h %h", nv, base, spread, done) != 4)
					fail_run($sformatf("bad stimulus line: %s", line));
				nv_q.push_back(nv);
				base_q.push_back(base);
				spread_q.push_back(spread);
				done_q.push_back(done);
			end
		end
		$fclose(fd);
		n_blocks = nv_q.size();
		if (n_blocks == 0) fail_run("the stimulus file holds no test blocks");
		loaded = 1'b1;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		for (b = 0; b < n_blocks; b++) begin
			apb_write(`APB_AW'h0, 32'(nv_q[b]));
			apb_read(`APB_AW'h0, rd);
			check_apb("noise_var", rd, {16'h0, 16'(nv_q[b])});
			for (int i = 0; i < `BLK_N; i++) begin
				rng = xorshift32(rng);
				val = base_q[b] + int'(rng % 32'(spread_q[b]));
				blk[i] = pix_t'((val > 255) ? 255 : val);   // saturate
			end
			build_model(nv_q[b]);
			fork
				send_block();
				collect_block();
			join
			apb_read(`APB_AW'h4, rd);
			check_apb("blocks_done", rd, 32'(done_q[b]));
			if (out_seen != (b + 1) * `BLK_N)
				fail_run($sformatf("after block %0d the DUT gave %0d output beats, expected %0d",
					b, out_seen, (b + 1) * `BLK_N));
		end
		$display("sim passed");
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (n_blocks * `BLK_N * 4 + 2000) @(posedge clk);
		fail_run("timeout, the run took longer than the test length allows");
	end

endmodule

// ==== wiener_stimulus.txt ====
# noise_var base spread blocks_done_after, all hex
# pixel = base + (xorshift mod spread), saturated to ff
0010 80 1 1
0000 20 40 2
2000 60 40 3
0010 0 100 4
0000 c0 80 5
0400 40 80 6
ffff 0 100 7
0000 0 1 8
0005 ff 1 9
1000 70 20 a

// ==== wiener_denoise_top.f ====
+incdir+.
wiener_pkg.sv
wiener_ctrl.sv
block_stats.sv
gain_divider.sv
block_buffer.sv
wiener_pixel.sv
wiener_denoise_top.sv
tb_wiener_denoise.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the denoiser testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_wiener_denoise \
	-f wiener_denoise_top.f --Mdir obj_dir -o tb_wiener_denoise
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_wiener_denoise > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi
exit 0
